/* files.f */
src/mlu_pkg.sv
src/mlu_slice.sv
src/mlu_operand_split.sv
src/mlu_result_stage.sv
src/mlu_top.sv
verification/mlu_checker.sv
verification/mlu_tb.sv

/* src/mlu_operand_split.sv */
// captures one request per in_valid pulse; no back-pressure, a new request may arrive every cycle
`timescale 1ns/1ps

module mlu_operand_split (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             in_valid,
  input  mlu_pkg::mlu_req_t                                req,
  output logic                                             valid_q,
  output mlu_pkg::mlu_req_t                                req_q,
  output mlu_pkg::mlu_slice_in_t [mlu_pkg::NUM_SLICES-1:0] slice_in
);

  import mlu_pkg::*;

  // strobe pipeline, one pulse out per pulse in
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // request register, holds between strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= '0;
    end else if (in_valid) begin
      req_q <= req;
    end
  end

  // fan out nibbles, every slice sees the same op
  always_comb begin
    for (int i = 0; i < NUM_SLICES; i++) begin
      slice_in[i].op    = req_q.op;
      slice_in[i].a_nib = req_q.a[i*SLICE_W +: SLICE_W];
      slice_in[i].b_nib = req_q.b[i*SLICE_W +: SLICE_W];
    end
  end

  // an unknown op would poison every slice and the flag logic downstream
  a_req_op_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> !$isunknown(req.op)
  ) else $error("mlu_operand_split: unknown op with in_valid high");

endmodule

/* src/mlu_pkg.sv */
// shared ALU types; widths and slice count are fixed by the instruction set and are not tunable
package mlu_pkg;

  localparam int DATA_W     = 16;                 // operand width
  localparam int SLICE_W    = 4;                  // width of one slice
  localparam int NUM_SLICES = DATA_W / SLICE_W;   // 4 slices

  // operation codes, encoding shared with the CPU decoder
  typedef enum logic [2:0] {
    mlu_add  = 3'd0,
    mlu_sub  = 3'd1,
    mlu_and  = 3'd2,
    mlu_or   = 3'd3,
    mlu_xor  = 3'd4,
    mlu_not  = 3'd5,
    mlu_anot = 3'd6,
    mlu_nop1 = 3'd7
  } mlu_op_t;

  // one request as presented at the ALU input
  typedef struct packed {
    mlu_op_t           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              carry_in;   // inverted borrow for sub
  } mlu_req_t;

  // per-slice operand fields, carry-in travels on its own wire
  typedef struct packed {
    mlu_op_t            op;
    logic [SLICE_W-1:0] a_nib;
    logic [SLICE_W-1:0] b_nib;
  } mlu_slice_in_t;

  // slice output byte, same bit order as the LUT slice
  typedef struct packed {
    logic               spare;     // always 0
    logic               zero;
    logic               gen;
    logic               prop;
    logic [SLICE_W-1:0] nibble;
  } mlu_slice_out_t;

  // registered ALU result with flags
  typedef struct packed {
    logic [DATA_W-1:0] value;
    logic              carry;
    logic              zero;
    logic              negative;
    logic              overflow;
  } mlu_result_t;

endpackage

/* src/mlu_result_stage.sv */
// lookahead carries feed back into the slices in the same cycle; result holds while out_valid is low
`timescale 1ns/1ps

module mlu_result_stage (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              valid_q,
  input  mlu_pkg::mlu_req_t                                 req_q,
  input  mlu_pkg::mlu_slice_out_t [mlu_pkg::NUM_SLICES-1:0] slice_out,
  output logic [mlu_pkg::NUM_SLICES-1:0]                    carry_vec,
  output logic                                              out_valid,
  output mlu_pkg::mlu_result_t                              result
);

  import mlu_pkg::*;

  logic [NUM_SLICES:0] carry_chain;   // carry into each slice, top bit is carry out
  logic                is_arith;
  logic                b_sign;        // sign of the effective b operand
  logic [DATA_W-1:0]   value;
  logic                all_zero;
  logic                ovf;
  mlu_result_t         result_d;

  assign is_arith = (req_q.op == mlu_add) || (req_q.op == mlu_sub);

  // slice 0 takes the request carry only for arithmetic
  always_comb begin
    carry_chain[0] = is_arith ? req_q.carry_in : 1'b0;
    for (int i = 0; i < NUM_SLICES; i++) begin
      carry_chain[i+1] = slice_out[i].gen | (slice_out[i].prop & carry_chain[i]);
    end
  end

  assign carry_vec = carry_chain[NUM_SLICES-1:0];

  // gather nibbles and zero bits
  always_comb begin
    all_zero = 1'b1;
    for (int i = 0; i < NUM_SLICES; i++) begin
      value[i*SLICE_W +: SLICE_W] = slice_out[i].nibble;
      all_zero                    = all_zero & slice_out[i].zero;
    end
  end

  // sub adds ~b, so its sign is inverted for the overflow test
  assign b_sign = (req_q.op == mlu_sub) ? ~req_q.b[DATA_W-1] : req_q.b[DATA_W-1];
  assign ovf    = is_arith && (req_q.a[DATA_W-1] == b_sign) &&
                  (value[DATA_W-1] != req_q.a[DATA_W-1]);

  always_comb begin
    result_d.value    = value;
    result_d.carry    = is_arith & carry_chain[NUM_SLICES]; // inverted borrow for sub
    result_d.zero     = all_zero;
    result_d.negative = value[DATA_W-1];
    result_d.overflow = ovf;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin
        result <= result_d;
      end
    end
  end

  // logic ops leave carry and overflow clear on the published result
  a_logic_no_carry: assert property (
    @(posedge clk) disable iff (!rst_n)
    (valid_q && !is_arith) |=> (!result.carry && !result.overflow)
  ) else $error("mlu_result_stage: carry or overflow set after a logic op");

  // exactly one result pulse per captured request, one cycle later
  a_out_valid_follows: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_q |=> out_valid
  ) else $error("mlu_result_stage: out_valid missing after valid_q");

endmodule

/* src/mlu_slice.sv */
// pure combinational 4-bit slice; prop and gen ignore carry_in so the lookahead network has no loop
`timescale 1ns/1ps

module mlu_slice (
  input  mlu_pkg::mlu_slice_in_t  slice_in,
  input  logic                    carry_in,
  output mlu_pkg::mlu_slice_out_t slice_out
);

  import mlu_pkg::*;

  logic [SLICE_W-1:0] a_nib;
  logic [SLICE_W-1:0] b_eff;     // b, inverted for sub
  logic [SLICE_W:0]   raw_sum;   // a + b_eff without carry-in
  logic [SLICE_W-1:0] nibble;
  logic               prop;
  logic               gen;

  assign a_nib = slice_in.a_nib;

  // two's complement subtract adds ~b plus the inverted borrow
  assign b_eff   = (slice_in.op == mlu_sub) ? ~slice_in.b_nib : slice_in.b_nib;
  assign raw_sum = {1'b0, a_nib} + {1'b0, b_eff};

  // logic ops never feed the carry chain
  always_comb begin
    nibble = '0;
    prop   = 1'b0;
    gen    = 1'b0;
    case (slice_in.op)
      mlu_add,
      mlu_sub: begin
        nibble = raw_sum[SLICE_W-1:0] + {{(SLICE_W-1){1'b0}}, carry_in};
        prop   = (raw_sum[SLICE_W-1:0] == {SLICE_W{1'b1}}); // carry-in passes through
        gen    = raw_sum[SLICE_W];                          // sum above fifteen
      end
      mlu_and: begin
        nibble = a_nib & slice_in.b_nib;
      end
      mlu_or: begin
        nibble = a_nib | slice_in.b_nib;
      end
      mlu_xor: begin
        nibble = a_nib ^ slice_in.b_nib;
      end
      mlu_not: begin
        nibble = ~a_nib; // b ignored
      end
      mlu_anot: begin
        nibble = a_nib & ~slice_in.b_nib;
      end
      default: begin
        nibble = '0; // mlu_nop1 returns zero
      end
    endcase
  end

  always_comb begin
    slice_out.spare  = 1'b0;
    slice_out.zero   = (nibble == '0);
    slice_out.gen    = gen;
    slice_out.prop   = prop;
    slice_out.nibble = nibble;
  end

endmodule

/* src/mlu_top.sv */
// 16-bit ALU, fixed 2-edge latency from in_valid to out_valid; the consumer must take every result
`timescale 1ns/1ps

module mlu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  mlu_pkg::mlu_req_t    req,
  output logic                 out_valid,
  output mlu_pkg::mlu_result_t result
);

  import mlu_pkg::*;

  logic                                  valid_q;
  mlu_req_t                              req_q;
  mlu_slice_in_t  [NUM_SLICES-1:0]       slice_in;
  mlu_slice_out_t [NUM_SLICES-1:0]       slice_out;
  logic           [NUM_SLICES-1:0]       carry_vec;   // lookahead carry per slice

  mlu_operand_split u_operand_split (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .req      (req),
    .valid_q  (valid_q),
    .req_q    (req_q),
    .slice_in (slice_in)
  );

  for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
    mlu_slice u_slice (
      .slice_in  (slice_in[i]),
      .carry_in  (carry_vec[i]),
      .slice_out (slice_out[i])
    );

    // slice has no clock, so its checks sample on the ALU clock here
    a_zero_matches: assert property (
      @(posedge clk) disable iff (!rst_n)
      valid_q |-> (slice_out[i].zero == (slice_out[i].nibble == '0))
    ) else $error("slice %0d: zero bit does not match nibble", i);

    a_logic_no_pg: assert property (
      @(posedge clk) disable iff (!rst_n)
      (valid_q && !(slice_in[i].op inside {mlu_add, mlu_sub})) |->
        (!slice_out[i].prop && !slice_out[i].gen)
    ) else $error("slice %0d: prop or gen set for a logic op", i);
  end

  mlu_result_stage u_result_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_q   (valid_q),
    .req_q     (req_q),
    .slice_out (slice_out),
    .carry_vec (carry_vec),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule

/* verification/mlu_checker.sv */
// ALU scoreboard; expects exactly one out_valid two edges after each in_valid, no back-pressure
`timescale 1ns/1ps

module mlu_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  mlu_pkg::mlu_req_t    req,
  input  logic                 out_valid,
  input  mlu_pkg::mlu_result_t result,
  output int                   check_count,
  output int                   error_count,
  output int                   test_count,
  output int                   failed_count
);

  import mlu_pkg::*;

  localparam int DRAIN_LIMIT = 64;   // cycles allowed for outstanding results

  mlu_req_t    pend_q[$];            // requests awaiting a result
  int          due_q[$];             // edge at which each result is due
  mlu_result_t last_result;
  mlu_req_t    head_req;
  int          head_due;
  int          cycle;
  int          test_checks;
  int          test_errors;
  string       cur_test;

  initial begin
    check_count  = 0;
    error_count  = 0;
    test_count   = 0;
    failed_count = 0;
    test_checks  = 0;
    test_errors  = 0;
    cycle        = 0;
    last_result  = '0;
  end

  // 17-bit arithmetic model of the ALU rules
  function automatic mlu_result_t expected_result(input mlu_req_t r);
    logic [16:0]     sum;
    logic [15:0]     b_eff;
    mlu_result_t     want;
    want  = '0;
    b_eff = (r.op == mlu_sub) ? ~r.b : r.b;
    sum   = {1'b0, r.a} + {1'b0, b_eff} + {16'h0000, r.carry_in};
    case (r.op)
      mlu_add, mlu_sub: begin
        want.value    = sum[15:0];
        want.carry    = sum[16];
        want.overflow = (r.a[15] == b_eff[15]) && (sum[15] != r.a[15]);
      end
      mlu_and:  want.value = r.a & r.b;
      mlu_or:   want.value = r.a | r.b;
      mlu_xor:  want.value = r.a ^ r.b;
      mlu_not:  want.value = ~r.a;
      mlu_anot: want.value = r.a & ~r.b;
      default:  want.value = 16'h0000;   // no-op
    endcase
    want.zero     = (want.value == 16'h0000);
    want.negative = want.value[15];
    return want;
  endfunction

  task automatic fail_plain(input string msg);
    $display("%s: %s", cur_test, msg);
    test_errors++;
    error_count++;
  endtask

  task automatic compare_result(input mlu_req_t r);
    mlu_result_t want;
    want = expected_result(r);
    test_checks++;
    check_count++;
    if (result !== want) begin
      $display("ERROR %s: op=%0d a=%h b=%h cin=%b expected %h/%b actual %h/%b",
               cur_test, r.op, r.a, r.b, r.carry_in,
               want.value, want[3:0], result.value, result[3:0]);
      test_errors++;
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      if (out_valid !== 1'b0) fail_plain("out_valid is not low during reset");
    end else begin
      cycle = cycle + 1;
      if (out_valid === 1'b1) begin
        if (pend_q.size() == 0) begin
          fail_plain("out_valid pulsed with no request outstanding");
        end else begin
          head_req = pend_q.pop_front();
          head_due = due_q.pop_front();
          if (head_due != cycle) fail_plain("result did not arrive two edges after request");
          compare_result(head_req);
        end
        last_result = result;
      end else begin
        if (due_q.size() != 0 && due_q[0] <= cycle) begin
          fail_plain("out_valid missing for an outstanding request");
          head_req = pend_q.pop_front();
          head_due = due_q.pop_front();
        end
        if (result !== last_result) fail_plain("result changed while out_valid was low");
      end
      if (in_valid === 1'b1) begin
        pend_q.push_back(req);
        due_q.push_back(cycle + 2);
      end
    end
  end

  task automatic begin_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  // sampled on the falling edge, away from the compare
  task automatic finish_test();
    int waited;
    waited = 0;
    @(negedge clk);
    while (pend_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (pend_q.size() != 0) begin
      fail_plain($sformatf("timed out with %0d results still outstanding", pend_q.size()));
      pend_q.delete();
      due_q.delete();
    end
    repeat (4) @(negedge clk);   // window for stray pulses
    test_count++;
    if (test_errors != 0) failed_count++;
    $display("test %s: %0d checks, %0d errors, %s", cur_test, test_checks, test_errors,
             (test_errors == 0) ? "ok" : "failed");
  endtask

endmodule

/* verification/mlu_tb.sv */
// directed and LCG-random traffic for mlu_top; the scoreboard lives in mlu_checker
`timescale 1ns/1ps

module mlu_tb;

  import mlu_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  mlu_req_t    req;
  logic        out_valid;
  mlu_result_t result;
  logic [31:0] rng_state;
  int          check_count;
  int          error_count;
  int          test_count;
  int          failed_count;

  always #5 clk = ~clk;

  mlu_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .result    (result)
  );

  mlu_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .req          (req),
    .out_valid    (out_valid),
    .result       (result),
    .check_count  (check_count),
    .error_count  (error_count),
    .test_count   (test_count),
    .failed_count (failed_count)
  );

  function automatic logic [15:0] rand16();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];   // upper bits are the better ones
  endfunction

  function automatic logic rand_bit();
    logic [15:0] v;
    v = rand16();
    return v[15];
  endfunction

  function automatic mlu_op_t rand_op();
    logic [15:0] v;
    v = rand16();
    return mlu_op_t'(v[2:0]);
  endfunction

  // in_valid stays high until the next call or go_idle
  task automatic send_req(input mlu_op_t op, input logic [15:0] a, input logic [15:0] b,
                          input logic cin);
    mlu_req_t r;
    r.op       = op;
    r.a        = a;
    r.b        = b;
    r.carry_in = cin;
    @(posedge clk);
    in_valid <= 1'b1;
    req      <= r;
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic close_test();
    go_idle(1);
    u_checker.finish_test();
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    req       = '0;
    rng_state = 32'h2147;

    u_checker.begin_test("reset_latency");
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    go_idle(8);                                 // no pulse before the first request
    for (int i = 0; i < 4; i++) begin
      send_req(mlu_add, rand16(), rand16(), rand_bit());
      go_idle(3);
    end
    close_test();

    u_checker.begin_test("add_sub");
    send_req(mlu_add, 16'hFFFF, 16'h0001, 1'b0);   // carry through all slices
    send_req(mlu_sub, 16'h0000, 16'h0001, 1'b1);   // borrow through all slices
    for (int i = 0; i < 40; i++) begin
      send_req(rand_bit() ? mlu_sub : mlu_add, rand16(), rand16(), rand_bit());
    end
    close_test();

    u_checker.begin_test("logic_ops");
    for (int k = 2; k < 8; k++) begin
      for (int j = 0; j < 10; j++) begin
        send_req(mlu_op_t'(k[2:0]), rand16(), rand16(), rand_bit());
      end
    end
    close_test();

    u_checker.begin_test("zero_negative");
    send_req(mlu_add, 16'h1234, 16'hEDCC, 1'b0);   // wraps to zero
    send_req(mlu_sub, 16'h5555, 16'h5555, 1'b1);
    send_req(mlu_xor, 16'hA5C3, 16'hA5C3, 1'b0);
    send_req(mlu_add, 16'h7FFF, 16'h0001, 1'b0);   // signed overflow into bit 15
    send_req(mlu_sub, 16'h0000, 16'h0001, 1'b1);
    send_req(mlu_and, 16'h8000, 16'hFFFF, 1'b0);
    send_req(mlu_nop1, 16'hFFFF, 16'hFFFF, 1'b1);
    close_test();

    u_checker.begin_test("throughput");
    for (int i = 0; i < 200; i++) begin
      send_req(rand_op(), rand16(), rand16(), rand_bit());
    end
    close_test();

    u_checker.begin_test("sparse");
    for (int i = 0; i < 60; i++) begin
      send_req(rand_op(), rand16(), rand16(), rand_bit());
      go_idle(1 + (rand16() % 5));
    end
    close_test();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_count, check_count, error_count);
    if (error_count == 0 && failed_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
